// File: design/alu_op_select.sv
`timescale 1ns/1ns

module alu_op_select (
    input  uc_pkg::exec_kind_e exec_kind,
    input  logic [2:0]         sub_op,
    input  logic               carry_flag,
    output uc_pkg::alu_op_e    alu_opcode,
    output logic               alu_carry
);

    always_comb begin
        alu_opcode = uc_pkg::alu_or;    // Also covers sub_op 7
        alu_carry  = 1'b0;
        if (exec_kind == uc_pkg::ex_one_op) begin
            case (sub_op)
                3'd0: begin     // INC
                    alu_opcode = uc_pkg::alu_adc;
                    alu_carry  = 1'b1;
                end
                3'd1: begin     // DEC
                    alu_opcode = uc_pkg::alu_sbb1;
                    alu_carry  = 1'b1;
                end
                3'd2: alu_opcode = uc_pkg::alu_sbb2;  // NEG
                3'd3: alu_opcode = uc_pkg::alu_not;
                3'd4: alu_opcode = uc_pkg::alu_shl;
                3'd5: alu_opcode = uc_pkg::alu_shr;
                3'd6: alu_opcode = uc_pkg::alu_sar;
                default: ;
            endcase
        end else if (exec_kind == uc_pkg::ex_two_op) begin
            case (sub_op)
                3'd0, 3'd1: alu_opcode = uc_pkg::alu_adc;    // ADD, ADC
                3'd2, 3'd3: alu_opcode = uc_pkg::alu_sbb1;   // SUB/CMP, SBB
                3'd4:       alu_opcode = uc_pkg::alu_and;    // AND/TEST
                3'd6:       alu_opcode = uc_pkg::alu_xor;
                default: ;
            endcase
            alu_carry = sub_op[0] && !sub_op[2] && carry_flag;  // ADC and SBB only
        end
    end

endmodule

// File: design/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  logic [uc_pkg::word_w-1:0] ri,
    plan_if.decoder                   plan
);

    logic [3:0] cls;
    logic [3:0] sub_f;
    logic [3:0] mod_f;
    logic [3:0] rg_f;
    logic [3:0] rm_f;
    logic       d;
    logic       is_reg;
    logic       is_ind;
    logic       is_1op;
    logic       known;
    logic       mem_dst;

    // Field bit 0 sits at the lowest ri index and ends up as the MSB
    function automatic logic [3:0] field(input logic [uc_pkg::word_w-1:0] w,
                                         input int pos,
                                         input int len);
        logic [3:0] f;
        f = '0;
        for (int i = 0; i < len; i++)
            f[len-1-i] = w[pos+i];
        return f;
    endfunction

    assign cls   = field(ri, uc_pkg::cls_pos, 4);
    assign sub_f = field(ri, uc_pkg::sub_pos, 3);
    assign mod_f = field(ri, uc_pkg::mod_pos, 2);
    assign rg_f  = field(ri, uc_pkg::rg_pos, 3);
    assign rm_f  = field(ri, uc_pkg::rm_pos, 3);
    assign d     = ri[uc_pkg::d_pos];

    assign is_reg  = mod_f[1:0] == uc_pkg::mod_reg;
    assign is_ind  = mod_f[1:0] == uc_pkg::mod_ind;
    assign is_1op  = cls == uc_pkg::cls_1op;
    assign known   = (is_reg || is_ind) &&
                     (is_1op || cls == uc_pkg::cls_2op_nostore || cls == uc_pkg::cls_2op_store);
    assign mem_dst = is_ind && (is_1op || !d);  // 1-op always works on its r/m operand

    always_comb begin
        plan.exec_kind  = uc_pkg::ex_none;
        plan.addr_mode  = uc_pkg::addr_none;
        plan.src_step   = uc_pkg::src_none;
        plan.dst_step   = mem_dst ? uc_pkg::dst_mem : uc_pkg::dst_reg;
        plan.store_step = uc_pkg::st_none;
        if (known) begin
            plan.exec_kind = is_1op ? uc_pkg::ex_one_op : uc_pkg::ex_two_op;
            if (is_ind)   // Single register when field bit 0 of rm is set
                plan.addr_mode = rm_f[2] ? uc_pkg::addr_reg_ind : uc_pkg::addr_base_idx;
            if (!is_1op)
                plan.src_step = (is_ind && d) ? uc_pkg::src_mem : uc_pkg::src_reg;
            if (cls != uc_pkg::cls_2op_nostore)
                plan.store_step = mem_dst ? uc_pkg::st_mem : uc_pkg::st_reg;
        end
    end

    assign plan.d      = d && !is_1op;      // Keeps the 1-op address in T1
    assign plan.sub_op = sub_f[2:0];
    assign plan.rg     = rg_f[2:0];
    assign plan.rm     = rm_f[2:0];

endmodule

// File: design/plan_if.sv
`timescale 1ns/1ns

interface plan_if;

    uc_pkg::addr_mode_e  addr_mode;
    uc_pkg::src_step_e   src_step;
    uc_pkg::dst_step_e   dst_step;
    uc_pkg::exec_kind_e  exec_kind;
    uc_pkg::store_step_e store_step;
    logic                d;         // Set when rg is the destination
    logic [2:0]          sub_op;
    logic [2:0]          rg;
    logic [2:0]          rm;        // rm[2] is field bit 0

    modport decoder (output addr_mode, src_step, dst_step, exec_kind, store_step,
                     output d, sub_op, rg, rm);
    modport seq     (input addr_mode, src_step, dst_step, exec_kind, store_step,
                     input d, sub_op, rg, rm);
    modport gen     (input addr_mode, src_step, dst_step, exec_kind, store_step,
                     input d, sub_op, rg, rm);

endinterface

// File: design/strobe_gen.sv
`timescale 1ns/1ns

module strobe_gen (
    input  uc_pkg::state_e  state,
    plan_if.gen             plan,
    input  logic            carry_flag,
    output logic            alu_oe,
    output logic            alu_carry,
    output uc_pkg::alu_op_e alu_opcode,
    output logic            ram_oe,
    output logic            ram_we,
    output logic            io_oe,
    output logic            io_we,
    output logic [2:0]      regs_addr,
    output logic            regs_oe,
    output logic            regs_we,
    output logic            cp_oe,
    output logic            cp_we,
    output logic            ind_sel,    // 1 = flags from ALU
    output logic            ind_oe,
    output logic            ind_we,
    output logic            am_oe,
    output logic            am_we,
    output logic            t1_oe,
    output logic            t1_we,
    output logic            t2_oe,
    output logic            t2_we,
    output logic            ri_oe,
    output logic            ri_we
);

    uc_pkg::alu_op_e exec_opcode;
    logic            exec_carry;
    logic [2:0]      src_addr;
    logic [2:0]      dst_addr;

    alu_op_select alu_sel_i (
        .exec_kind  (plan.exec_kind),
        .sub_op     (plan.sub_op),
        .carry_flag (carry_flag),
        .alu_opcode (exec_opcode),
        .alu_carry  (exec_carry)
    );

    assign src_addr = plan.d ? plan.rm : plan.rg;
    assign dst_addr = plan.d ? plan.rg : plan.rm;

    // No port I/O, jump offset or flag readback in this subset
    assign io_oe  = 1'b0;
    assign io_we  = 1'b0;
    assign ri_oe  = 1'b0;
    assign ind_oe = 1'b0;

    always_comb begin
        {alu_oe, alu_carry, ram_oe, ram_we, regs_oe, regs_we, cp_oe, cp_we} = '0;
        {ind_sel, ind_we, am_oe, am_we, t1_oe, t1_we, t2_oe, t2_we, ri_we} = '0;
        alu_opcode = uc_pkg::alu_or;    // T OR 0 passes a temporary to the bus
        regs_addr  = uc_pkg::reg_ra;
        case (state)
            uc_pkg::fetch_0: begin          // AM <- CP
                cp_oe = 1'b1;
                am_we = 1'b1;
            end
            uc_pkg::fetch_1, uc_pkg::load_src_mem_1, uc_pkg::load_dst_mem_1:
                am_oe = 1'b1;               // RAM address from AM
            uc_pkg::fetch_2: begin          // RI <- RAM
                ram_oe = 1'b1;
                ri_we  = 1'b1;
            end
            uc_pkg::addr_sum_0: begin
                regs_addr = plan.rm[1] ? uc_pkg::reg_bb : uc_pkg::reg_ba;
                regs_oe   = 1'b1;
                t1_we     = 1'b1;
            end
            uc_pkg::addr_sum_1: begin
                regs_addr = plan.rm[0] ? uc_pkg::reg_xb : uc_pkg::reg_xa;
                regs_oe   = 1'b1;
                t2_we     = 1'b1;
            end
            uc_pkg::addr_sum_2: begin       // Base + index into the memory operand temp
                {t1_oe, t2_oe, alu_oe} = 3'b111;
                alu_opcode = uc_pkg::alu_adc;
                t2_we      = plan.d;
                t1_we      = !plan.d;
            end
            uc_pkg::addr_reg: begin
                regs_addr = plan.rm;
                regs_oe   = 1'b1;
                t2_we     = plan.d;
                t1_we     = !plan.d;
            end
            uc_pkg::load_src_reg: begin
                regs_addr = src_addr;
                regs_oe   = 1'b1;
                t2_we     = 1'b1;
            end
            uc_pkg::load_src_mem_0, uc_pkg::load_dst_mem_0: begin     // AM <- T2 or T1
                t1_oe  = state == uc_pkg::load_dst_mem_0;
                t2_oe  = state == uc_pkg::load_src_mem_0;
                alu_oe = 1'b1;
                am_we  = 1'b1;
            end
            uc_pkg::load_src_mem_2: begin
                ram_oe = 1'b1;
                t2_we  = 1'b1;
            end
            uc_pkg::load_dst_reg: begin
                regs_addr = dst_addr;
                regs_oe   = 1'b1;
                t1_we     = 1'b1;
            end
            uc_pkg::load_dst_mem_2: begin
                ram_oe = 1'b1;
                t1_we  = 1'b1;
            end
            uc_pkg::exec_1op, uc_pkg::exec_2op: begin   // T1 <- T1 op T2, flags too
                t1_oe      = 1'b1;
                t2_oe      = state == uc_pkg::exec_2op;
                alu_opcode = exec_opcode;
                alu_carry  = exec_carry;
                alu_oe     = 1'b1;
                t1_we      = 1'b1;
                ind_sel    = 1'b1;
                ind_we     = 1'b1;
            end
            uc_pkg::store_reg: begin
                {t1_oe, alu_oe, regs_we} = 3'b111;
                regs_addr = dst_addr;
            end
            uc_pkg::store_mem_0:            // RAM[AM] <- T1
                {t1_oe, alu_oe, am_oe, ram_we} = 4'b1111;
            uc_pkg::inc_cp_0: begin
                cp_oe = 1'b1;
                t1_we = 1'b1;
            end
            uc_pkg::inc_cp_1: begin         // CP <- T1 + 1
                {t1_oe, alu_oe, cp_we} = 3'b111;
                alu_opcode = uc_pkg::alu_adc;
                alu_carry  = 1'b1;
            end
            default: ;
        endcase

        // One bus driver at a time
        assert ($onehot0({regs_oe, ram_oe, cp_oe, alu_oe}));
        assert (!(regs_oe && regs_we));
    end

endmodule

// File: design/uc.sv
`timescale 1ns/1ns

module uc (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [uc_pkg::word_w-1:0]  ri,
    input  logic [uc_pkg::word_w-1:0]  ind,
    output logic                       alu_oe,
    output logic                       alu_carry,
    output logic [3:0]                 alu_opcode,
    output logic                       ram_oe,
    output logic                       ram_we,
    output logic                       io_oe,
    output logic                       io_we,
    output logic [2:0]                 regs_addr,
    output logic                       regs_oe,
    output logic                       regs_we,
    output logic                       cp_oe,
    output logic                       cp_we,
    output logic                       ind_sel,
    output logic                       ind_oe,
    output logic                       ind_we,
    output logic                       am_oe,
    output logic                       am_we,
    output logic                       t1_oe,
    output logic                       t1_we,
    output logic                       t2_oe,
    output logic                       t2_we,
    output logic                       ri_oe,
    output logic                       ri_we,
    output logic [uc_pkg::state_w-1:0] disp_state
);

    uc_pkg::state_e state;

    plan_if dec_plan ();    // Live decode of ri
    plan_if lat_plan ();    // Held for the current instruction

    instr_decoder dec_i (
        .ri   (ri),
        .plan (dec_plan.decoder)
    );

    uc_sequencer seq_i (
        .clk   (clk),
        .rst   (rst),
        .dec   (dec_plan.seq),
        .lat   (lat_plan.decoder),
        .state (state)
    );

    strobe_gen gen_i (
        .state      (state),
        .plan       (lat_plan.gen),
        .carry_flag (ind[uc_pkg::flag_carry]),
        .alu_oe     (alu_oe),
        .alu_carry  (alu_carry),
        .alu_opcode (alu_opcode),
        .ram_oe     (ram_oe),
        .ram_we     (ram_we),
        .io_oe      (io_oe),
        .io_we      (io_we),
        .regs_addr  (regs_addr),
        .regs_oe    (regs_oe),
        .regs_we    (regs_we),
        .cp_oe      (cp_oe),
        .cp_we      (cp_we),
        .ind_sel    (ind_sel),
        .ind_oe     (ind_oe),
        .ind_we     (ind_we),
        .am_oe      (am_oe),
        .am_we      (am_we),
        .t1_oe      (t1_oe),
        .t1_we      (t1_we),
        .t2_oe      (t2_oe),
        .t2_we      (t2_we),
        .ri_oe      (ri_oe),
        .ri_we      (ri_we)
    );

    assign disp_state = state;

endmodule

// File: design/uc_pkg.sv
package uc_pkg;

    localparam int word_w  = 16;
    localparam int state_w = 16;

    // Field offsets in ri
    // Bit 0 of every field is its MSB
    localparam int cls_pos = 0;     // Class, upper part of cop
    localparam int sub_pos = 4;     // Sub-operation, lower part of cop
    localparam int d_pos   = 7;
    localparam int mod_pos = 8;
    localparam int rg_pos  = 10;
    localparam int rm_pos  = 13;

    localparam logic [3:0] cls_1op         = 4'b0001;
    localparam logic [3:0] cls_2op_nostore = 4'b0100;   // CMP, TEST
    localparam logic [3:0] cls_2op_store   = 4'b0101;

    localparam logic [1:0] mod_reg = 2'b11;
    localparam logic [1:0] mod_ind = 2'b00;

    localparam int flag_carry = 0;

    //////////////////////////////////////////////////////////////////////
    // Sequencer states, grouped by 16 per phase
    typedef enum logic [state_w-1:0] {
        reset          = 16'h00,
        fetch_0        = 16'h10,
        fetch_1        = 16'h11,
        fetch_2        = 16'h12,
        decode         = 16'h20,
        addr_sum_0     = 16'h30,
        addr_sum_1     = 16'h31,
        addr_sum_2     = 16'h32,
        addr_reg       = 16'h34,
        load_src_reg   = 16'h40,
        load_src_mem_0 = 16'h44,
        load_src_mem_1 = 16'h45,
        load_src_mem_2 = 16'h46,
        load_dst_reg   = 16'h50,
        load_dst_mem_0 = 16'h54,
        load_dst_mem_1 = 16'h55,
        load_dst_mem_2 = 16'h56,
        exec_1op       = 16'h60,
        exec_2op       = 16'h64,
        store_reg      = 16'h70,
        store_mem_0    = 16'h74,
        store_mem_1    = 16'h75,
        inc_cp_0       = 16'h80,
        inc_cp_1       = 16'h81
    } state_e;

    typedef enum logic [3:0] {
        alu_adc, alu_sbb1, alu_sbb2, alu_not, alu_and,
        alu_or, alu_xor, alu_shl, alu_shr, alu_sar
    } alu_op_e;

    typedef enum logic [2:0] {
        reg_ra, reg_rb, reg_rc, reg_is, reg_xa, reg_xb, reg_ba, reg_bb
    } reg_idx_e;

    //////////////////////////////////////////////////////////////////////
    // Decoded plan, one step kind per phase
    typedef enum logic [1:0] {addr_none, addr_reg_ind, addr_base_idx} addr_mode_e;
    typedef enum logic [1:0] {src_none, src_reg, src_mem} src_step_e;
    typedef enum logic       {dst_reg, dst_mem} dst_step_e;
    typedef enum logic [1:0] {ex_none, ex_one_op, ex_two_op} exec_kind_e;
    typedef enum logic [1:0] {st_none, st_reg, st_mem} store_step_e;

endpackage

// File: design/uc_sequencer.sv
`timescale 1ns/1ns

module uc_sequencer (
    input  logic           clk,
    input  logic           rst,
    plan_if.seq            dec,
    plan_if.decoder        lat,
    output uc_pkg::state_e state
);

    uc_pkg::state_e state_next;

    function automatic uc_pkg::state_e dst_entry(input uc_pkg::dst_step_e dst);
        return (dst == uc_pkg::dst_mem) ? uc_pkg::load_dst_mem_0 : uc_pkg::load_dst_reg;
    endfunction

    // First operand step once the address is known
    function automatic uc_pkg::state_e src_entry(input uc_pkg::src_step_e src,
                                                 input uc_pkg::dst_step_e dst);
        case (src)
            uc_pkg::src_reg: return uc_pkg::load_src_reg;
            uc_pkg::src_mem: return uc_pkg::load_src_mem_0;
            default:         return dst_entry(dst);    // 1-op has no source
        endcase
    endfunction

    always_comb begin
        state_next = uc_pkg::reset;
        case (state)
            uc_pkg::reset:   state_next = uc_pkg::fetch_0;
            uc_pkg::fetch_0: state_next = uc_pkg::fetch_1;
            uc_pkg::fetch_1: state_next = uc_pkg::fetch_2;
            uc_pkg::fetch_2: state_next = uc_pkg::decode;
            uc_pkg::decode: begin   // Latch loads this cycle so steer from the decoder
                if (dec.exec_kind == uc_pkg::ex_none)
                    state_next = uc_pkg::inc_cp_0;
                else if (dec.addr_mode == uc_pkg::addr_base_idx)
                    state_next = uc_pkg::addr_sum_0;
                else if (dec.addr_mode == uc_pkg::addr_reg_ind)
                    state_next = uc_pkg::addr_reg;
                else
                    state_next = src_entry(dec.src_step, dec.dst_step);
            end
            uc_pkg::addr_sum_0: state_next = uc_pkg::addr_sum_1;
            uc_pkg::addr_sum_1: state_next = uc_pkg::addr_sum_2;
            uc_pkg::addr_sum_2, uc_pkg::addr_reg:
                state_next = src_entry(lat.src_step, lat.dst_step);
            uc_pkg::load_src_mem_0: state_next = uc_pkg::load_src_mem_1;
            uc_pkg::load_src_mem_1: state_next = uc_pkg::load_src_mem_2;
            uc_pkg::load_src_reg, uc_pkg::load_src_mem_2:
                state_next = dst_entry(lat.dst_step);
            uc_pkg::load_dst_mem_0: state_next = uc_pkg::load_dst_mem_1;
            uc_pkg::load_dst_mem_1: state_next = uc_pkg::load_dst_mem_2;
            uc_pkg::load_dst_reg, uc_pkg::load_dst_mem_2:
                state_next = (lat.exec_kind == uc_pkg::ex_two_op) ? uc_pkg::exec_2op
                                                                   : uc_pkg::exec_1op;
            uc_pkg::exec_1op, uc_pkg::exec_2op: begin
                case (lat.store_step)
                    uc_pkg::st_reg: state_next = uc_pkg::store_reg;
                    uc_pkg::st_mem: state_next = uc_pkg::store_mem_0;
                    default:        state_next = uc_pkg::inc_cp_0;    // CMP, TEST
                endcase
            end
            uc_pkg::store_mem_0: state_next = uc_pkg::store_mem_1;
            uc_pkg::store_reg, uc_pkg::store_mem_1: state_next = uc_pkg::inc_cp_0;
            uc_pkg::inc_cp_0: state_next = uc_pkg::inc_cp_1;
            uc_pkg::inc_cp_1: state_next = uc_pkg::fetch_0;
            default:          state_next = uc_pkg::reset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state          <= uc_pkg::reset;
            lat.addr_mode  <= uc_pkg::addr_none;
            lat.src_step   <= uc_pkg::src_none;
            lat.dst_step   <= uc_pkg::dst_reg;
            lat.exec_kind  <= uc_pkg::ex_none;
            lat.store_step <= uc_pkg::st_none;
            lat.d          <= 1'b0;
            lat.sub_op     <= '0;
            lat.rg         <= '0;
            lat.rm         <= '0;
        end else begin
            state <= state_next;
            if (state == uc_pkg::decode) begin
                lat.addr_mode  <= dec.addr_mode;
                lat.src_step   <= dec.src_step;
                lat.dst_step   <= dec.dst_step;
                lat.exec_kind  <= dec.exec_kind;
                lat.store_step <= dec.store_step;
                lat.d          <= dec.d;     // Operand fields
                lat.sub_op     <= dec.sub_op;
                lat.rg         <= dec.rg;
                lat.rm         <= dec.rm;
            end
        end
    end

    a_state_known: assert property (@(posedge clk) disable iff (!rst)
        state inside {uc_pkg::reset, uc_pkg::fetch_0, uc_pkg::fetch_1, uc_pkg::fetch_2,
            uc_pkg::decode, uc_pkg::addr_sum_0, uc_pkg::addr_sum_1, uc_pkg::addr_sum_2,
            uc_pkg::addr_reg, uc_pkg::load_src_reg, uc_pkg::load_src_mem_0,
            uc_pkg::load_src_mem_1, uc_pkg::load_src_mem_2, uc_pkg::load_dst_reg,
            uc_pkg::load_dst_mem_0, uc_pkg::load_dst_mem_1, uc_pkg::load_dst_mem_2,
            uc_pkg::exec_1op, uc_pkg::exec_2op, uc_pkg::store_reg, uc_pkg::store_mem_0,
            uc_pkg::store_mem_1, uc_pkg::inc_cp_0, uc_pkg::inc_cp_1});

    // Plan stays frozen for the whole instruction
    a_latch_hold: assert property (@(posedge clk) disable iff (!rst)
        state != uc_pkg::decode |=> $stable({lat.addr_mode, lat.src_step, lat.dst_step,
            lat.exec_kind, lat.store_step, lat.d, lat.sub_op, lat.rg, lat.rm}));

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the control unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module uc_tb -f uc.f \
    && ./obj_dir/Vuc_tb | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    && echo "uc_tb: passed" \
    || { echo "uc_tb: failed"; exit 1; }

// File: sim/uc_vectors.svh
// Columns: cls sub d mod rg rm | carry | cycles | alu op, carry in | store, store reg | reg0 reg1
// op 15 = no exec cycle, store 0 none 1 reg 2 mem, reg 8 = no regs_oe cycle

typedef struct packed {
    int cls;
    int sub;
    int d;
    int mod;
    int rg;
    int rm;
    int carry;
    int cycles;
    int op;
    int cin;
    int st;
    int st_addr;
    int reg0;
    int reg1;
} vec_t;

localparam int no_op  = 15;
localparam int no_reg = 8;

vec_t vecs [56] = '{
    // Two operands with store, register form
    '{5, 0, 1, 3, 0, 7, 0, 10, 0, 0, 1, 0, 7, 0},     // ADD
    '{5, 0, 1, 3, 0, 7, 1, 10, 0, 0, 1, 0, 7, 0},
    '{5, 0, 0, 3, 0, 7, 0, 10, 0, 0, 1, 7, 0, 7},
    '{5, 0, 0, 3, 0, 7, 1, 10, 0, 0, 1, 7, 0, 7},
    '{5, 1, 1, 3, 1, 6, 0, 10, 0, 0, 1, 1, 6, 1},     // ADC
    '{5, 1, 1, 3, 1, 6, 1, 10, 0, 1, 1, 1, 6, 1},
    '{5, 1, 0, 3, 1, 6, 0, 10, 0, 0, 1, 6, 1, 6},
    '{5, 1, 0, 3, 1, 6, 1, 10, 0, 1, 1, 6, 1, 6},
    '{5, 2, 1, 3, 2, 5, 0, 10, 1, 0, 1, 2, 5, 2},     // SUB
    '{5, 2, 1, 3, 2, 5, 1, 10, 1, 0, 1, 2, 5, 2},
    '{5, 2, 0, 3, 2, 5, 0, 10, 1, 0, 1, 5, 2, 5},
    '{5, 2, 0, 3, 2, 5, 1, 10, 1, 0, 1, 5, 2, 5},
    '{5, 3, 1, 3, 3, 4, 0, 10, 1, 0, 1, 3, 4, 3},     // SBB
    '{5, 3, 1, 3, 3, 4, 1, 10, 1, 1, 1, 3, 4, 3},
    '{5, 3, 0, 3, 3, 4, 0, 10, 1, 0, 1, 4, 3, 4},
    '{5, 3, 0, 3, 3, 4, 1, 10, 1, 1, 1, 4, 3, 4},
    '{5, 4, 1, 3, 4, 3, 0, 10, 4, 0, 1, 4, 3, 4},     // AND
    '{5, 4, 1, 3, 4, 3, 1, 10, 4, 0, 1, 4, 3, 4},
    '{5, 4, 0, 3, 4, 3, 0, 10, 4, 0, 1, 3, 4, 3},
    '{5, 4, 0, 3, 4, 3, 1, 10, 4, 0, 1, 3, 4, 3},
    '{5, 5, 1, 3, 5, 2, 0, 10, 5, 0, 1, 5, 2, 5},     // OR
    '{5, 5, 1, 3, 5, 2, 1, 10, 5, 0, 1, 5, 2, 5},
    '{5, 5, 0, 3, 5, 2, 0, 10, 5, 0, 1, 2, 5, 2},
    '{5, 5, 0, 3, 5, 2, 1, 10, 5, 0, 1, 2, 5, 2},
    '{5, 6, 1, 3, 6, 1, 0, 10, 6, 0, 1, 6, 1, 6},     // XOR
    '{5, 6, 1, 3, 6, 1, 1, 10, 6, 0, 1, 6, 1, 6},
    '{5, 6, 0, 3, 6, 1, 0, 10, 6, 0, 1, 1, 6, 1},
    '{5, 6, 0, 3, 6, 1, 1, 10, 6, 0, 1, 1, 6, 1},
    // One operand, register then indirect memory
    '{1, 0, 0, 3, 0, 1, 1, 9, 0, 1, 1, 1, 1, 8},      // INC
    '{1, 1, 0, 3, 1, 2, 0, 9, 1, 1, 1, 2, 2, 8},
    '{1, 2, 0, 3, 2, 3, 1, 9, 2, 0, 1, 3, 3, 8},
    '{1, 3, 0, 3, 3, 4, 0, 9, 3, 0, 1, 4, 4, 8},
    '{1, 4, 0, 3, 4, 5, 1, 9, 7, 0, 1, 5, 5, 8},
    '{1, 5, 0, 3, 5, 6, 0, 9, 8, 0, 1, 6, 6, 8},
    '{1, 6, 0, 3, 6, 7, 1, 9, 9, 0, 1, 7, 7, 8},      // SAR
    '{1, 0, 0, 0, 0, 4, 0, 13, 0, 1, 2, 0, 4, 8},
    '{1, 1, 0, 0, 0, 5, 1, 13, 1, 1, 2, 0, 5, 8},
    '{1, 2, 0, 0, 0, 6, 0, 13, 2, 0, 2, 0, 6, 8},
    '{1, 3, 0, 0, 0, 7, 1, 13, 3, 0, 2, 0, 7, 8},
    '{1, 4, 0, 0, 0, 4, 0, 13, 7, 0, 2, 0, 4, 8},
    '{1, 5, 0, 0, 0, 5, 1, 13, 8, 0, 2, 0, 5, 8},
    '{1, 6, 0, 0, 0, 6, 0, 13, 9, 0, 2, 0, 6, 8},
    // Base plus index
    '{5, 0, 1, 0, 2, 0, 0, 15, 0, 0, 1, 2, 6, 4},
    '{5, 3, 0, 0, 1, 3, 1, 16, 1, 1, 2, 0, 7, 5},
    '{1, 0, 0, 0, 0, 1, 0, 15, 0, 1, 2, 0, 6, 5},
    '{1, 6, 0, 0, 0, 2, 1, 15, 9, 0, 2, 0, 7, 4},
    // CMP and TEST over every addressing form
    '{4, 2, 1, 3, 1, 2, 0, 9, 1, 0, 0, 0, 2, 1},
    '{4, 4, 1, 0, 3, 5, 1, 12, 4, 0, 0, 0, 5, 3},
    '{4, 2, 0, 0, 0, 6, 1, 12, 1, 0, 0, 0, 6, 0},
    '{4, 4, 1, 0, 2, 2, 0, 14, 4, 0, 0, 0, 7, 4},
    '{4, 2, 0, 0, 5, 1, 1, 14, 1, 0, 0, 0, 6, 5},
    // Unsupported class or mod
    '{3, 0, 0, 3, 0, 0, 0, 6, 15, 0, 0, 0, 8, 8},
    '{5, 0, 0, 1, 0, 0, 1, 6, 15, 0, 0, 0, 8, 8},
    '{1, 0, 0, 2, 0, 0, 0, 6, 15, 0, 0, 0, 8, 8},
    '{4, 0, 0, 2, 0, 0, 1, 6, 15, 0, 0, 0, 8, 8},
    '{0, 0, 0, 0, 0, 0, 0, 6, 15, 0, 0, 0, 8, 8}
};

// File: sim/uc_tb.sv
`timescale 1ns/1ns

module uc_tb;

    logic        clk;
    logic        rst;
    logic [15:0] ri;
    logic [15:0] ind;
    logic        alu_oe;
    logic        alu_carry;
    logic [3:0]  alu_opcode;
    logic        ram_oe;
    logic        ram_we;
    logic        io_oe;
    logic        io_we;
    logic [2:0]  regs_addr;
    logic        regs_oe;
    logic        regs_we;
    logic        cp_oe;
    logic        cp_we;
    logic        ind_sel;
    logic        ind_oe;
    logic        ind_we;
    logic        am_oe;
    logic        am_we;
    logic        t1_oe;
    logic        t1_we;
    logic        t2_oe;
    logic        t2_we;
    logic        ri_oe;
    logic        ri_we;
    logic [15:0] disp_state;

    int cycle_cnt   = 0;
    int cycle_limit = 0;

    `include "uc_vectors.svh"

    uc uc_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
            abort_run($sformatf("Timeout: no end of test after %0d clock cycles", cycle_limit));
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("FAILED at time %0t: %s is %0d, expected %0d",
                                $time, name, got, exp));
    endtask

    function automatic string row_tag(input string sig, input int idx);
        return $sformatf("%s (row %0d)", sig, idx);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Field bit 0 is the MSB and sits at the lowest ri index
    function automatic logic [15:0] instr_word(input vec_t v);
        logic [15:0] w;
        w = '0;
        for (int i = 0; i < 4; i++)
            w[i] = v.cls[3-i];
        for (int i = 0; i < 3; i++) begin
            w[4+i]  = v.sub[2-i];
            w[10+i] = v.rg[2-i];
            w[13+i] = v.rm[2-i];
        end
        w[7] = v.d[0];
        w[8] = v.mod[1];
        w[9] = v.mod[0];
        return w;
    endfunction

    task automatic verify_idle_in_reset();
        expect_equal("disp_state", 32'(disp_state), 32'(uc_pkg::reset));
        expect_equal("strobes", 32'({alu_oe, alu_carry, ram_oe, ram_we, io_oe, io_we,
            regs_oe, regs_we, cp_oe, cp_we, ind_sel, ind_oe, ind_we, am_oe, am_we,
            t1_oe, t1_we, t2_oe, t2_we, ri_oe, ri_we}), 0);
    endtask

    // One instruction, from its fetch_0 to the next fetch_0
    task automatic run_vector(input int idx, input vec_t v);
        logic [31:0] r;
        logic [15:0] word;
        logic [15:0] flags;
        int          n_cyc = 0;
        int          n_ind = 0;
        int          n_cp = 0;
        int          n_rwe = 0;
        int          n_mwe = 0;
        int          n_oe = 0;
        int          oe_addr [2] = '{no_reg, no_reg};
        int          we_addr = no_reg;

        word = instr_word(v);
        r = $urandom;
        if (v.op == no_op)      // Only class and mod pick the unsupported path
            word = (word & 16'h030f) | (r[15:0] & ~16'h030f);
        r = $urandom;
        flags = r[15:0];
        flags[0] = v.carry[0];  // Carry flag

        while (disp_state !== 16'(uc_pkg::fetch_0))
            @(negedge clk);
        do begin
            n_cyc++;
            n_cp  += int'(cp_we);
            n_mwe += int'(ram_we);
            if (regs_oe === 1'b1 && n_oe < 2) begin
                oe_addr[n_oe] = int'(regs_addr);
                n_oe++;
            end
            if (regs_we === 1'b1) begin
                n_rwe++;
                we_addr = int'(regs_addr);
            end
            if (ind_we === 1'b1) begin  // Exec cycle
                n_ind++;
                expect_equal(row_tag("alu_opcode", idx), 32'(alu_opcode), v.op);
                expect_equal(row_tag("alu_carry", idx), 32'(alu_carry), v.cin);
            end
            @(posedge clk);
            if (n_cyc == 1) begin
                ri  <= word;
                ind <= flags;
            end
            @(negedge clk);
        end while (disp_state !== 16'(uc_pkg::fetch_0));

        expect_equal(row_tag("cycle count", idx), n_cyc, v.cycles);
        expect_equal(row_tag("ind_we pulses", idx), n_ind, (v.op == no_op) ? 0 : 1);
        expect_equal(row_tag("cp_we pulses", idx), n_cp, 1);
        expect_equal(row_tag("regs_we pulses", idx), n_rwe, (v.st == 1) ? 1 : 0);
        expect_equal(row_tag("ram_we pulses", idx), n_mwe, (v.st == 2) ? 1 : 0);
        if (v.st == 1)
            expect_equal(row_tag("regs_addr on regs_we", idx), we_addr, v.st_addr);
        expect_equal(row_tag("first regs_oe regs_addr", idx), oe_addr[0], v.reg0);
        expect_equal(row_tag("second regs_oe regs_addr", idx), oe_addr[1], v.reg1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        rst = 1'b0;
        ri  = '0;
        ind = '0;
        void'($urandom(75));
        cycle_limit = 5 + 2 + 20;   // Reset, reset state and fetch entry, slack
        foreach (vecs[i])
            cycle_limit += vecs[i].cycles;

        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            verify_idle_in_reset();
        end
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        verify_idle_in_reset();     // Reset state lasts one more cycle
        @(negedge clk);
        expect_equal("disp_state", 32'(disp_state), 32'(uc_pkg::fetch_0));
        expect_equal("cp_oe", 32'(cp_oe), 1);
        expect_equal("am_we", 32'(am_we), 1);

        foreach (vecs[i])
            run_vector(i, vecs[i]);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: uc.f
+incdir+sim
design/uc_pkg.sv
design/plan_if.sv
design/instr_decoder.sv
design/uc_sequencer.sv
design/alu_op_select.sv
design/strobe_gen.sv
design/uc.sv
sim/uc_tb.sv
